//--- src/apb_fifo_regs.sv
`timescale 1ns/100ps

module apb_fifo_regs
  import bridge_pkg::*;
  import apb_pkg::*;
(
  input  logic               rd_clk,
  input  logic               wr_rst_n,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp,
  input  sample_t            rd_sample,
  input  logic               empty,
  input  logic               aempty,
  input  logic               afull,
  input  logic [LEVEL_W-1:0] level,
  output logic               rd_en
);

  logic                  setup_q;
  logic                  access;
  logic                  status_rd;
  logic                  data_rd;
  logic                  bad_access;
  logic [APB_DATA_W-1:0] status;

  // an access phase only counts right after a setup cycle.
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= apb_req.psel && !apb_req.penable;
    end
  end

  assign access    = apb_req.psel && apb_req.penable && setup_q;
  assign status_rd = access && !apb_req.pwrite && (apb_req.paddr == REG_STATUS);
  assign data_rd   = access && !apb_req.pwrite && (apb_req.paddr == REG_DATA);
  assign rd_en     = data_rd && !empty;

  // writes, unmapped addresses and data reads while empty.
  assign bad_access = access && !status_rd && !rd_en;

  always_comb begin
    status                                    = '0;
    status[STATUS_EMPTY_BIT]                  = empty;
    status[STATUS_AEMPTY_BIT]                 = aempty;
    status[STATUS_AFULL_BIT]                  = afull;
    status[STATUS_LEVEL_MSB:STATUS_LEVEL_LSB] = level;
  end

  // no wait states.
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = bad_access;
    apb_rsp.prdata  = '0;
    if (status_rd) begin
      apb_rsp.prdata = status;
    end else if (rd_en) begin
      apb_rsp.prdata = rd_sample;
    end
  end

  // a pop belongs to a transfer set up as a data read and lasts one cycle.
  a_pop_in_data_read : assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    rd_en |-> $past(apb_req.psel && !apb_req.penable && !apb_req.pwrite &&
                    (apb_req.paddr == REG_DATA)) ##1 !rd_en);

endmodule

//--- src/apb_pkg.sv
package apb_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                  pready;
    logic                  pslverr;
    logic [APB_DATA_W-1:0] prdata;
  } apb_rsp_t;

  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_DATA   = 8'h04;

  // status word layout.
  localparam int STATUS_EMPTY_BIT  = 0;
  localparam int STATUS_AEMPTY_BIT = 1;
  localparam int STATUS_AFULL_BIT  = 2;
  localparam int STATUS_LEVEL_LSB  = 16;
  localparam int STATUS_LEVEL_MSB  = 31;

endpackage

//--- src/async_fifo.sv
`timescale 1ns/100ps

module async_fifo
  import bridge_pkg::*;
#(
  parameter int FIFO_DEPTH   = 16,
  parameter int AFULL_LEVEL  = 14,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic               wr_clk,
  input  logic               rd_clk,
  input  logic               wr_rst_n,
  input  logic               wr_en,
  input  sample_t            wr_sample,
  output logic               full,
  input  logic               rd_en,
  output sample_t            rd_sample,
  output logic               empty,
  output logic               aempty,
  output logic               afull,
  output logic [LEVEL_W-1:0] level
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int PTR_W  = ADDR_W + 1;

  logic             wr_push;
  logic             rd_pop;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr;
  // each pointer as seen from the other clock domain.
  logic [PTR_W-1:0] rd_ptr_wr;
  logic [PTR_W-1:0] wr_ptr_rd;
  logic [PTR_W-1:0] fill_cnt;

  assign wr_push = wr_en && !full;
  assign rd_pop  = rd_en && !empty;

  dual_port_ram #(
    .DEPTH  (FIFO_DEPTH),
    .ADDR_W (ADDR_W)
  ) i_dual_port_ram (
    .wr_clk    (wr_clk),
    .wr_en     (wr_push),
    .wr_addr   (wr_ptr[ADDR_W-1:0]),
    .wr_sample (wr_sample),
    .rd_addr   (rd_ptr[ADDR_W-1:0]),
    .rd_sample (rd_sample)
  );

  gray_sync #(
    .PTR_W (PTR_W)
  ) i_wr_ptr_sync (
    .src_clk  (wr_clk),
    .dst_clk  (rd_clk),
    .wr_rst_n (wr_rst_n),
    .src_ptr  (wr_ptr),
    .dst_ptr  (wr_ptr_rd)
  );

  gray_sync #(
    .PTR_W (PTR_W)
  ) i_rd_ptr_sync (
    .src_clk  (rd_clk),
    .dst_clk  (wr_clk),
    .wr_rst_n (wr_rst_n),
    .src_ptr  (rd_ptr),
    .dst_ptr  (rd_ptr_wr)
  );

  assign wr_ptr_nxt = wr_ptr + PTR_W'(wr_push);

  // full rises on the edge that fills the last entry.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
      full   <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      full   <= (wr_ptr_nxt[ADDR_W] != rd_ptr_wr[ADDR_W]) &&
                (wr_ptr_nxt[ADDR_W-1:0] == rd_ptr_wr[ADDR_W-1:0]);
    end
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_ptr <= '0;
    end else if (rd_pop) begin
      rd_ptr <= rd_ptr + PTR_W'(1);
    end
  end

  // the synchronized write pointer lags, so level can only understate.
  assign empty    = (rd_ptr == wr_ptr_rd);
  // the difference wraps at the pointer width.
  assign fill_cnt = wr_ptr_rd - rd_ptr;
  assign level    = LEVEL_W'(fill_cnt);
  assign aempty   = (level <= LEVEL_W'(AEMPTY_LEVEL));
  assign afull    = (level >= LEVEL_W'(AFULL_LEVEL));

  a_no_write_full : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_en |-> !full);

  a_no_read_empty : assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    rd_en |-> !empty);

  a_level_bound : assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    level <= LEVEL_W'(FIFO_DEPTH));

endmodule

//--- src/bridge_pkg.sv
package bridge_pkg;

  localparam int CHAN_W  = 4;
  localparam int SEQ_W   = 12;
  localparam int DATA_W  = 16;

  // width of the level field in status, so FIFO_DEPTH stays at or below 32768.
  localparam int LEVEL_W = 16;

  // one 32-bit FIFO word; seq wraps at 4096.
  typedef struct packed {
    logic [CHAN_W-1:0] channel;
    logic [SEQ_W-1:0]  seq;
    logic [DATA_W-1:0] data;
  } sample_t;

endpackage

//--- src/dual_port_ram.sv
`timescale 1ns/100ps

module dual_port_ram
  import bridge_pkg::*;
#(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 4
) (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  sample_t           wr_sample,
  input  logic [ADDR_W-1:0] rd_addr,
  output sample_t           rd_sample
);

  sample_t mem [0:DEPTH-1];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_sample;
    end
  end

  // read is combinational so the head word is already on rd_sample.
  assign rd_sample = mem[rd_addr];

endmodule

//--- src/gray_sync.sv
`timescale 1ns/100ps

module gray_sync #(
  parameter int PTR_W = 5
) (
  input  logic             src_clk,
  input  logic             dst_clk,
  input  logic             wr_rst_n,
  input  logic [PTR_W-1:0] src_ptr,
  output logic [PTR_W-1:0] dst_ptr
);

  logic [PTR_W-1:0] src_gray;
  logic [PTR_W-1:0] sync_q1;
  logic [PTR_W-1:0] sync_q2;

  // the crossing starts from a flop, never from the encoder logic.
  always_ff @(posedge src_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_ptr ^ (src_ptr >> 1);
    end
  end

  always_ff @(posedge dst_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= src_gray;
      sync_q2 <= sync_q1;
    end
  end

  // binary bit i is the xor of all gray bits from i upward.
  always_comb begin
    for (int i = 0; i < PTR_W; i++) begin
      dst_ptr[i] = ^(sync_q2 >> i);
    end
  end

  // a step of more than one bit could be captured as a pointer that never existed.
  a_gray_one_bit : assert property (@(posedge src_clk) disable iff (!wr_rst_n)
    $countones(src_gray ^ $past(src_gray)) <= 1);

endmodule

//--- src/sample_capture.sv
`timescale 1ns/100ps

module sample_capture
  import bridge_pkg::*;
(
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              s_valid,
  input  logic [CHAN_W-1:0] s_channel,
  input  logic [DATA_W-1:0] s_data,
  output logic              s_ready,
  input  logic              full,
  output logic              wr_en,
  output sample_t           wr_sample
);

  logic [SEQ_W-1:0] seq_cnt;

  // back-pressure comes straight from the FIFO full flag.
  assign s_ready = !full;
  assign wr_en   = s_valid && s_ready;

  // counts accepted samples and wraps at 4096.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      seq_cnt <= '0;
    end else if (wr_en) begin
      seq_cnt <= seq_cnt + SEQ_W'(1);
    end
  end

  always_comb begin
    wr_sample.channel = s_channel;
    wr_sample.seq     = seq_cnt;
    wr_sample.data    = s_data;
  end

endmodule

//--- src/stream_bridge_top.sv
`timescale 1ns/100ps

module stream_bridge_top
  import bridge_pkg::*;
  import apb_pkg::*;
#(
  parameter int FIFO_DEPTH   = 16,
  parameter int AFULL_LEVEL  = 14,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic              wr_clk,
  input  logic              rd_clk,
  input  logic              wr_rst_n,
  input  logic              s_valid,
  input  logic [CHAN_W-1:0] s_channel,
  input  logic [DATA_W-1:0] s_data,
  output logic              s_ready,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp
);

  logic               full;
  logic               wr_en;
  sample_t            wr_sample;
  logic               rd_en;
  sample_t            rd_sample;
  logic               empty;
  logic               aempty;
  logic               afull;
  logic [LEVEL_W-1:0] level;

  sample_capture i_sample_capture (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .s_valid   (s_valid),
    .s_channel (s_channel),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .full      (full),
    .wr_en     (wr_en),
    .wr_sample (wr_sample)
  );

  async_fifo #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_LEVEL  (AFULL_LEVEL),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) i_async_fifo (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_sample (wr_sample),
    .full      (full),
    .rd_en     (rd_en),
    .rd_sample (rd_sample),
    .empty     (empty),
    .aempty    (aempty),
    .afull     (afull),
    .level     (level)
  );

  apb_fifo_regs i_apb_fifo_regs (
    .rd_clk    (rd_clk),
    .wr_rst_n  (wr_rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .rd_sample (rd_sample),
    .empty     (empty),
    .aempty    (aempty),
    .afull     (afull),
    .level     (level),
    .rd_en     (rd_en)
  );

endmodule

//--- test/bridge_patterns.txt
# one operation per line, operands in hex:
# P chan data | F count | D chan data | Q count | R addr prdata pslverr
# W addr wdata pslverr | S status | B s_ready | H chan data | J
R 00 00000003 0
B 1
P 1 1111
P 2 2222
P 7 7777
P f 0abc
S 00040000
D 1 1111
D 2 2222
D 7 7777
D f 0abc
S 00000003
R 04 00000000 1
R 00 00000003 0
F 10
S 00100004
B 0
H 5 abcd
B 0
Q 1
J
S 00100004
W 00 12345678 1
W 04 deadbeef 1
R 0c 00000000 1
R 00 00100004 0
Q d
S 00030000
Q 1
S 00020002
Q 1
S 00010002
D 5 abcd
S 00000003

//--- test/stream_bridge_tb.sv
`timescale 1ns/100ps

module stream_bridge_tb
  import bridge_pkg::*;
  import apb_pkg::*;
();

  localparam int FIFO_DEPTH   = 16;
  localparam int AFULL_LEVEL  = 14;
  localparam int AEMPTY_LEVEL = 2;
  localparam int WAIT_LIMIT   = 200;

  logic              rd_clk;
  logic              wr_clk;
  logic              wr_rst_n;
  logic              s_valid;
  logic [CHAN_W-1:0] s_channel;
  logic [DATA_W-1:0] s_data;
  logic              s_ready;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;

  // predicted samples in push order with seq from the accepted count.
  sample_t           expected_q[$];
  int                accepted;
  int                err_cnt;
  int                test_cnt;
  int                fail_cnt;
  bit                timed_out;
  bit                held_done;
  logic [CHAN_W-1:0] held_ch;
  logic [DATA_W-1:0] held_data;

  tb_clock_gen #(.PERIOD(4.0)) i_rd_clk_gen (.clk(rd_clk));
  tb_clock_gen #(.PERIOD(6.0)) i_wr_clk_gen (.clk(wr_clk));

  stream_bridge_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_LEVEL  (AFULL_LEVEL),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) i_stream_bridge_top (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .wr_rst_n  (wr_rst_n),
    .s_valid   (s_valid),
    .s_channel (s_channel),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic push_sample(input logic [CHAN_W-1:0] ch, input logic [DATA_W-1:0] data);
    int      waited;
    sample_t exp;
    waited = 0;
    @(negedge wr_clk);
    repeat ($urandom % 3) @(negedge wr_clk);
    s_valid   = 1'b1;
    s_channel = ch;
    s_data    = data;
    while (!s_ready && waited < WAIT_LIMIT) begin
      @(negedge wr_clk);
      waited++;
    end
    if (!s_ready) begin
      $display("timeout at %0t: s_ready stayed low while a sample was held", $time);
      timed_out = 1'b1;
    end else begin
      @(posedge wr_clk);
      exp.channel = ch;
      exp.seq     = SEQ_W'(accepted);
      exp.data    = data;
      expected_q.push_back(exp);
      accepted++;
      @(negedge wr_clk);
    end
    s_valid = 1'b0;
  endtask

  // setup then access phase with the response sampled before the access edge.
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output apb_rsp_t rsp);
    @(negedge rd_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge rd_clk);
    apb_req.penable = 1'b1;
    #1;
    rsp = apb_rsp;
    check_value("pready", 32'(1), 32'(rsp.pready));
    @(negedge rd_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_data(input bit from_file, input logic [CHAN_W-1:0] ch,
                           input logic [DATA_W-1:0] data);
    sample_t  exp;
    apb_rsp_t rsp;
    if (expected_q.size() == 0) begin
      $display("a data read was requested but no sample had been pushed");
      err_cnt++;
    end else begin
      exp = expected_q.pop_front();
      if (from_file) begin
        exp.channel = ch;
        exp.data    = data;
      end
      apb_access(1'b0, REG_DATA, '0, rsp);
      check_value("prdata", exp, rsp.prdata);
      check_value("pslverr", 32'(0), 32'(rsp.pslverr));
    end
  endtask

  task automatic wait_status(input logic [31:0] exp);
    int       tries;
    apb_rsp_t rsp;
    tries = 0;
    apb_access(1'b0, REG_STATUS, '0, rsp);
    while (rsp.prdata !== exp && tries < WAIT_LIMIT) begin
      apb_access(1'b0, REG_STATUS, '0, rsp);
      tries++;
    end
    if (rsp.prdata !== exp) begin
      $display("timeout at %0t: status never reached %h, last read %h", $time, exp, rsp.prdata);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_held_push();
    int waited;
    waited = 0;
    while (!held_done && waited < WAIT_LIMIT) begin
      @(negedge wr_clk);
      waited++;
    end
    if (!held_done) begin
      $display("timeout at %0t: the held sample was never accepted", $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_op(input byte op, input logic [31:0] f1, input logic [31:0] f2,
                        input logic [31:0] f3);
    apb_rsp_t rsp;
    case (op)
      "P": push_sample(f1[CHAN_W-1:0], f2[DATA_W-1:0]);
      "F": begin
        // fill data spans the whole index.
        for (int i = 0; i < f1 && !timed_out; i++) begin
          push_sample(CHAN_W'(i), {i[7:0], ~i[7:0]});
        end
      end
      "D": read_data(1'b1, f1[CHAN_W-1:0], f2[DATA_W-1:0]);
      "Q": begin
        for (int i = 0; i < f1; i++) begin
          read_data(1'b0, '0, '0);
        end
      end
      "R": begin
        apb_access(1'b0, f1[7:0], '0, rsp);
        check_value("prdata", f2, rsp.prdata);
        check_value("pslverr", 32'(f3[0]), 32'(rsp.pslverr));
      end
      "W": begin
        apb_access(1'b1, f1[7:0], f2, rsp);
        check_value("pslverr", 32'(f3[0]), 32'(rsp.pslverr));
      end
      "S": wait_status(f1);
      "B": begin
        repeat (4) @(negedge wr_clk);
        check_value("s_ready", 32'(f1[0]), 32'(s_ready));
      end
      "H": begin
        held_ch   = f1[CHAN_W-1:0];
        held_data = f2[DATA_W-1:0];
        held_done = 1'b0;
        fork
          begin
            push_sample(held_ch, held_data);
            held_done = 1'b1;
          end
        join_none
      end
      "J": wait_held_push();
      default: begin
        $display("unknown operation %c in the pattern file", op);
        err_cnt++;
      end
    endcase
  endtask

  initial begin
    string       line;
    byte         op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    int          fd;
    int          errs_before;
    void'($urandom(32'h2659c45a));
    wr_rst_n  = 1'b0;
    s_valid   = 1'b0;
    s_channel = '0;
    s_data    = '0;
    apb_req   = '0;
    repeat (10) @(posedge rd_clk);
    // release 1 ns after a rd_clk fall to stay clear of every edge of both clocks.
    @(negedge rd_clk);
    #1;
    wr_rst_n = 1'b1;
    fd = $fopen("test/bridge_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file test/bridge_patterns.txt");
      err_cnt++;
    end else begin
      while (!timed_out && $fgets(line, fd)) begin
        if (line.len() > 1 && line[0] != "#") begin
          void'($sscanf(line, "%c %h %h %h", op, f1, f2, f3));
          errs_before = err_cnt;
          run_op(op, f1, f2, f3);
          test_cnt++;
          if (err_cnt != errs_before || timed_out) begin
            fail_cnt++;
            $display("test %0d (%c) FAILED", test_cnt, op);
          end else begin
            $display("test %0d (%c) ok", test_cnt, op);
          end
        end
      end
      $fclose(fd);
    end
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real PERIOD = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2.0);
      clk = ~clk;
    end
  end

endmodule

//--- vlog.f
src/bridge_pkg.sv
src/apb_pkg.sv
src/gray_sync.sv
src/dual_port_ram.sv
src/async_fifo.sv
src/sample_capture.sv
src/apb_fifo_regs.sv
src/stream_bridge_top.sv
test/tb_clock_gen.sv
test/stream_bridge_tb.sv
